// File: testbench/objdma_tests.txt
# W addr data is a CPU byte write to work RAM, F waits for one frame copy, S is F with grant drops
# R name index entry expects obj_entry {attr,b2,b1,b0} at the object index, all values hex
R reset_zero 5a 00000000
W 000 11
W 001 22
W 002 33
W 003 f4
W 3fc a1
W 3fd b2
W 3fe c3
W 3ff 1e
W 2d0 5c
W 2d1 6d
W 2d2 7e
W 2d3 e9
F
R first_idx0 00 14332211
R first_idx255 ff 1ec3b2a1
R attr_mask_idx5a 5a 097e6d5c
W 024 48
W 025 59
W 026 6a
W 027 ff
S
R stall_idx81 81 1f6a5948
R stall_idx0 00 14332211
R stall_idx5a 5a 097e6d5c
W 000 99
W 3fc 77
R hold_idx0 00 14332211
R hold_idx255 ff 1ec3b2a1
F
R next_idx0 00 14332299
R next_idx255 ff 1ec3b277

// File: sources.f
design/objdma_pkg.sv
design/video_timing.sv
design/main_work_ram.sv
design/objdma_ctrl.sv
design/obj_attr_banks.sv
design/objdma_top.sv
testbench/objdma_chk.sv
testbench/objdma_tb.sv

// File: Makefile
# Verilator build and run of the object DMA testbench

VERILATOR  ?= verilator
TOP        := objdma_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/objdma_tb.sv
/* Testbench for the object DMA. A CPU model grants the bus and writes work RAM,
   steps come from testbench/objdma_tests.txt, object entries are checked */

module objdma_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import objdma_pkg::*;

    localparam int LINE_PIXELS  = 256;
    localparam int FRAME_LINES  = 40;
    localparam int VBLANK_LINES = 20;
    localparam int FRAME_CLKS   = 2 * LINE_PIXELS * FRAME_LINES;   // Two clk per pixel
    localparam int COPY_CLKS    = 8 * DMA_BYTES;    // Four pixels per byte, two clk per pixel

    logic       clk     = 1'b0;
    logic       rst_n;
    logic       busak_n = 1'b1;     // No grant until asked
    logic       cpu_we;
    logic [9:0] cpu_addr;
    logic [7:0] cpu_din;
    logic [7:0] obj_index;
    logic       busrq_n;
    logic       vblank;
    obj_entry_t obj_entry;

    // Steps parsed from the data file
    string       step_kind [$];
    string       step_name [$];
    logic [31:0] step_arg1 [$];     // Address or object index
    logic [31:0] step_arg2 [$];     // Byte or expected entry

    logic stall_mode  = 1'b0;       // Random grant withdrawals
    int   stall_left  = 0;
    int   frame_steps = 0;          // F and S steps in the file
    int   cycles      = 0;
    int   cycle_limit = 0;          // Zero until the file is counted
    int   edges       = 0;          // clk edges since reset release

    objdma_top #(
        .LINE_PIXELS  ( LINE_PIXELS  ),
        .FRAME_LINES  ( FRAME_LINES  ),
        .VBLANK_LINES ( VBLANK_LINES )
    ) objdma_top_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .busak_n   ( busak_n   ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_din   ( cpu_din   ),
        .obj_index ( obj_index ),
        .busrq_n   ( busrq_n   ),
        .vblank    ( vblank    ),
        .obj_entry ( obj_entry )
    );

    always #4 clk = ~clk;           // 8 ns period

    // Run length guard, one frame per F or S step plus two spare
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the steps did not finish within %0d clock cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "run stopped by the cycle counter");
        end
    end

    // CPU bus grant, with random stretches of withdrawal in stall mode
    initial begin
        void'($urandom(32'h9a28_a0af));
        forever begin
            @(posedge clk);
            #1;
            if (busrq_n) begin
                busak_n    = 1'b1;      // Bus released
                stall_left = 0;
            end else if (stall_left != 0) begin
                stall_left = stall_left - 1;
                busak_n    = 1'b1;
            end else if (stall_mode && ($urandom % 100) == 0) begin
                stall_left = 8 + ($urandom % 32);   // Covers at least one slot
                busak_n    = 1'b1;
            end else begin
                busak_n = 1'b0;
            end
        end
    end

    // Vertical blank against the frame layout, one pixel every second clk
    always @(posedge clk) begin
        if (rst_n) begin
            edges = edges + 1;
            #1;
            check_value("vblank", 32'(expected_vblank(edges)), 32'(vblank));
        end
    end

    function automatic logic expected_vblank(input int n);
        int line;
        line = (n / (2 * LINE_PIXELS)) % FRAME_LINES;
        return line >= FRAME_LINES - VBLANK_LINES;   // Last lines of the frame
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #1;                         // Drive and sample off the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic cpu_write(input logic [9:0] addr, input logic [7:0] data);
        while (!busrq_n)
            next_cycle();           // CPU holds off while DMA owns the bus
        cpu_addr = addr;
        cpu_din  = data;
        cpu_we   = 1'b1;
        next_cycle();               // RAM takes the byte here
        cpu_we   = 1'b0;
    endtask

    // Copy starts at the vblank rise, done once the request is back up
    task automatic wait_copy(input logic stalled);
        int busy;
        busy = 0;
        while (busrq_n)
            next_cycle();
        while (!busrq_n) begin
            next_cycle();
            busy = busy + 1;        // Clks with the bus requested
        end
        while (vblank)
            next_cycle();
        // Full-speed copy is 1024 slots plus less than one slot to line up
        if (stalled)
            check_value("stall_copy_len", 1, 32'(busy > COPY_CLKS + 8));
        else
            check_value("frame_copy_len", 1, 32'(busy >= COPY_CLKS && busy <= COPY_CLKS + 8));
    endtask

    task automatic read_entry(input string name, input logic [7:0] index,
                              input logic [28:0] expected);
        obj_index = index;
        next_cycle();               // Registered read port
        check_value(name, 32'(expected), 32'(obj_entry));
    endtask

    task automatic load_steps;
        int               fd;
        int               n;
        int               want;
        int               ch;
        logic [8*32-1:0]  tok_raw;
        logic [8*32-1:0]  name_raw;
        logic [31:0]      a;
        logic [31:0]      b;
        string            tok;
        fd = $fopen("testbench/objdma_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the step file testbench/objdma_tests.txt");
            $display("Testbench failed");
            $fatal(1, "no step file");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok_raw);
            if (n != 1)
                break;              // End of file
            tok      = string'(tok_raw);
            name_raw = '0;
            a        = '0;
            b        = '0;
            if (tok == "#") begin
                ch = $fgetc(fd);    // Skip the comment line
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
            end else begin
                want = (tok == "W") ? 2 : (tok == "R") ? 3 : 0;
                if (tok == "W")
                    n = $fscanf(fd, "%h %h", a, b);
                else if (tok == "R")
                    n = $fscanf(fd, "%s %h %h", name_raw, a, b);
                else if (tok == "F" || tok == "S")
                    n = 0;
                else
                    n = -1;         // Unknown step letter
                if (n != want) begin
                    $display("Step file has a malformed line starting with %s", tok);
                    $display("Testbench failed");
                    $fatal(1, "bad step file");
                end
                if (tok == "F" || tok == "S")
                    frame_steps = frame_steps + 1;
                step_kind.push_back(tok);
                step_name.push_back(string'(name_raw));
                step_arg1.push_back(a);
                step_arg2.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        obj_index = '0;
        load_steps();
        cycle_limit = (frame_steps + 2) * FRAME_CLKS;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value("reset_busrq", 32'(1'b1), 32'(busrq_n));
        foreach (step_kind[k]) begin
            if (step_kind[k] == "W") begin
                cpu_write(step_arg1[k][9:0], step_arg2[k][7:0]);
            end else if (step_kind[k] == "R") begin
                read_entry(step_name[k], step_arg1[k][7:0], step_arg2[k][28:0]);
            end else begin
                stall_mode = step_kind[k] == "S";
                wait_copy(stall_mode);
                stall_mode = 1'b0;
            end
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: testbench/objdma_chk.sv
/* Concurrent checks on the DMA control, bound into every objdma_ctrl.
   Covers the bus request protocol and the bank write strobes */

module objdma_chk (
    input logic                      clk,
    input logic                      rst_n,
    input objdma_pkg::video_timing_t timing,
    input logic                      busrq_n,
    input objdma_pkg::bank_wr_t      bank_wr
);

    timeunit 1ns;
    timeprecision 100ps;

    // Request stays released through reset and right after it
    a_reset_rq: assert property (@(posedge clk) !rst_n |=> busrq_n)
        else $error("bus request not high out of reset");

    // Request falls one clk after vblank went from low to high
    a_rq_vb: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busrq_n) |-> $past(timing.vblank) && !$past(timing.vblank, 2))
        else $error("bus request fell without a vblank rise");

    // Banks only written while the bus is requested
    a_no_wr_idle: assert property (@(posedge clk) disable iff (!rst_n)
        busrq_n |-> bank_wr.we == 4'b0000)
        else $error("bank strobe while bus request is high");

    // One bank per strobe, only in the write phase of a slot
    a_one_bank: assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr.we != 4'b0000 |-> $onehot(bank_wr.we) && timing.cen && timing.phase == 2'd3)
        else $error("bank strobe on more than one bank or outside the write phase");

endmodule

bind objdma_ctrl objdma_chk objdma_chk_i (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .timing  ( timing  ),
    .busrq_n ( busrq_n ),
    .bank_wr ( bank_wr )
);

// File: design/objdma_top.sv
/* Object DMA top level: timing generator, work RAM, DMA control and attribute
   banks. The CPU and the object renderer sit outside on the ports */

module objdma_top #(
    parameter int LINE_PIXELS  = 256,
    parameter int FRAME_LINES  = 40,
    parameter int VBLANK_LINES = 20
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   busak_n,     // Bus grant from the CPU
    input  logic                   cpu_we,
    input  logic [9:0]             cpu_addr,
    input  logic [7:0]             cpu_din,
    input  logic [7:0]             obj_index,
    output logic                   busrq_n,     // Bus request to the CPU
    output logic                   vblank,
    output objdma_pkg::obj_entry_t obj_entry
);

    import objdma_pkg::*;

    // VBLANK_LINES * LINE_PIXELS must be at least 4 * DMA_BYTES,
    // otherwise the copy cannot finish inside vertical blank

    video_timing_t timing;
    bank_wr_t      bank_wr;
    logic          dma_cs;
    logic [9:0]    dma_addr;
    logic [7:0]    dma_data;

    assign vblank = timing.vblank;

    video_timing #(
        .LINE_PIXELS  ( LINE_PIXELS  ),
        .FRAME_LINES  ( FRAME_LINES  ),
        .VBLANK_LINES ( VBLANK_LINES )
    ) video_timing_i (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .timing ( timing )
    );

    main_work_ram main_work_ram_i (
        .clk      ( clk        ),
        .cpu_we   ( cpu_we     ),
        .cpu_addr ( cpu_addr   ),
        .cpu_din  ( cpu_din    ),
        .dma_cs   ( dma_cs     ),
        .dma_addr ( dma_addr   ),
        .cen      ( timing.cen ),   // Read data held per pixel
        .dma_data ( dma_data   )
    );

    objdma_ctrl objdma_ctrl_i (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .timing   ( timing   ),
        .busak_n  ( busak_n  ),
        .dma_data ( dma_data ),
        .busrq_n  ( busrq_n  ),
        .dma_cs   ( dma_cs   ),
        .dma_addr ( dma_addr ),
        .bank_wr  ( bank_wr  )
    );

    obj_attr_banks obj_attr_banks_i (
        .clk       ( clk       ),
        .bank_wr   ( bank_wr   ),
        .obj_index ( obj_index ),
        .obj_entry ( obj_entry )
    );

endmodule

// File: design/obj_attr_banks.sv
/* Four object-attribute banks of 256 entries. Written byte-wise by the DMA,
   read by the renderer as one registered 29-bit object entry */

module obj_attr_banks (
    input  logic                   clk,
    input  objdma_pkg::bank_wr_t   bank_wr,
    input  logic [7:0]             obj_index,   // Renderer object select
    output objdma_pkg::obj_entry_t obj_entry
);

    logic [7:0] byte_bank [0:2][0:255];  // Banks 0 to 2, full bytes
    logic [4:0] attr_bank [0:255];       // Bank 3, only 5 bits wired on the board

    // Banks come up cleared
    initial begin
        for (int i = 0; i < 256; i++) begin
            byte_bank[0][i] = 8'h00;
            byte_bank[1][i] = 8'h00;
            byte_bank[2][i] = 8'h00;
            attr_bank[i]    = 5'h00;
        end
    end

    // One write port per byte bank
    for (genvar b = 0; b < 3; b++) begin : g_byte_bank
        always_ff @(posedge clk) begin
            if (bank_wr.we[b])
                byte_bank[b][bank_wr.addr] <= bank_wr.data;
        end
    end

    // Attribute bank drops the top three bits
    always_ff @(posedge clk) begin
        if (bank_wr.we[3])
            attr_bank[bank_wr.addr] <= bank_wr.data[4:0];
    end

    // Common read port, one clk latency
    always_ff @(posedge clk) begin
        obj_entry.b0   <= byte_bank[0][obj_index];
        obj_entry.b1   <= byte_bank[1][obj_index];
        obj_entry.b2   <= byte_bank[2][obj_index];
        obj_entry.attr <= attr_bank[obj_index];
    end

endmodule

// File: design/objdma_ctrl.sv
/* Object DMA control: requests the CPU bus at vblank, then copies 1024 bytes
   of work RAM into the attribute banks, one byte per four-pixel slot */

module objdma_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  objdma_pkg::video_timing_t timing,
    input  logic                      busak_n,   // Bus grant from the CPU
    input  logic [7:0]                dma_data,  // Byte read from work RAM
    output logic                      busrq_n,   // Bus request to the CPU
    output logic                      dma_cs,    // RAM select for DMA
    output logic [9:0]                dma_addr,
    output objdma_pkg::bank_wr_t      bank_wr
);

    import objdma_pkg::*;

    // One extra bit marks the end of the copy
    localparam int CNT_W = $clog2(DMA_BYTES) + 1;

    dma_state_t       state;
    logic [CNT_W-1:0] cnt;          // Copy counter
    logic             vb_l;         // Last vblank
    logic             vb_rise;
    logic             slot_rd;      // Phase 1, RAM read issued
    logic             slot_wr;      // Phase 3, bank written
    logic             copy_end;
    logic             wr_en;

    assign vb_rise  = timing.vblank && !vb_l;
    assign slot_rd  = timing.cen && timing.phase == 2'd1;
    assign slot_wr  = timing.cen && timing.phase == 2'd3;
    assign copy_end = cnt[CNT_W-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= DMA_IDLE;
            busrq_n <= 1'b1;
            dma_cs  <= 1'b0;
            cnt     <= '0;
            vb_l    <= 1'b0;
        end else begin
            vb_l <= timing.vblank;
            case (state)
                DMA_IDLE: if (vb_rise) begin
                    busrq_n <= 1'b0;            // Ask the CPU for the bus
                    cnt     <= '0;
                    state   <= DMA_REQ;
                end
                DMA_REQ: if (slot_rd && !busak_n) begin
                    dma_cs <= 1'b1;             // First granted slot
                    state  <= DMA_COPY;
                end
                DMA_COPY: begin
                    // Grant sampled once per slot
                    if (slot_rd)
                        dma_cs <= ~busak_n;
                    if (wr_en)
                        cnt <= cnt + 1'b1;
                    if (copy_end) begin
                        busrq_n <= 1'b1;        // Hand the bus back
                        dma_cs  <= 1'b0;
                        state   <= DMA_DONE;
                    end
                end
                DMA_DONE: if (!timing.vblank)
                    state <= DMA_IDLE; // Rearm for the next frame
                default: state <= DMA_IDLE;
            endcase
        end
    end

    // Board address scramble of the counter
    always_comb begin
        dma_addr[2] = cnt[0];
        dma_addr[6] = cnt[1];
        dma_addr[3] = cnt[2];
        dma_addr[4] = cnt[3];
        dma_addr[7] = cnt[4];
        dma_addr[8] = cnt[5];
        dma_addr[9] = cnt[6];
        dma_addr[5] = cnt[7];
        dma_addr[0] = cnt[8];
        dma_addr[1] = cnt[9];
    end

    // Only a slot granted at phase 1 writes a bank
    assign wr_en = state == DMA_COPY && dma_cs && slot_wr && !copy_end;

    always_comb begin
        bank_wr.we   = wr_en ? 4'b0001 << cnt[9:8] : 4'b0000;  // Bank from top bits
        bank_wr.addr = cnt[7:0];
        bank_wr.data = dma_data;
    end

endmodule

// File: design/main_work_ram.sv
/* Main work RAM shared by the CPU and the object DMA. The DMA select steals
   the address bus; read data is registered on the pixel enable */

module main_work_ram (
    input  logic       clk,
    input  logic       cpu_we,      // CPU write strobe
    input  logic [9:0] cpu_addr,
    input  logic [7:0] cpu_din,
    input  logic       dma_cs,      // DMA owns the RAM
    input  logic [9:0] dma_addr,    // Already permuted by the control
    input  logic       cen,
    output logic [7:0] dma_data
);

    logic [7:0] mem [0:1023];
    logic [9:0] addr;               // Address after the bus mux
    logic       cpu_wr;

    // Board powers up with a cleared RAM image
    initial begin
        for (int i = 0; i < 1024; i++)
            mem[i] = 8'h00;
    end

    assign addr   = dma_cs ? dma_addr : cpu_addr;
    assign cpu_wr = cpu_we && !dma_cs;      // CPU locked out during DMA

    // CPU side writes on any clk
    always_ff @(posedge clk) begin
        if (cpu_wr)
            mem[addr] <= cpu_din;
    end

    // DMA side read, held between pixel enables
    always_ff @(posedge clk) begin
        if (cen)
            dma_data <= mem[addr]; // Stable by the bank-write phase
    end

endmodule

// File: design/video_timing.sv
/* Video timing generator: pixel enable at half clk, byte-slot phase,
   pixel and line counters, horizontal and vertical blank flags */

module video_timing #(
    parameter int LINE_PIXELS  = 256,
    parameter int FRAME_LINES  = 40,
    parameter int VBLANK_LINES = 20
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output objdma_pkg::video_timing_t timing
);

    localparam int HW = $clog2(LINE_PIXELS);
    localparam int VW = $clog2(FRAME_LINES);

    logic          cen;     // High on every second clk
    logic [HW-1:0] hcnt;    // Pixel inside the line
    logic [VW-1:0] vcnt;    // Line inside the frame
    logic          line_end;

    assign line_end = hcnt == HW'(LINE_PIXELS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen  <= 1'b0;
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            cen <= ~cen;
            if (cen) begin
                if (line_end) begin
                    hcnt <= '0;
                    // Wrap the frame on the last line
                    if (vcnt == VW'(FRAME_LINES - 1))
                        vcnt <= '0;
                    else
                        vcnt <= vcnt + 1'b1;
                end else begin
                    hcnt <= hcnt + 1'b1;
                end
            end
        end
    end

    // Four pixels per byte slot, so the phase is the low pixel count
    always_comb begin
        timing.cen    = cen;
        timing.phase  = hcnt[1:0];
        timing.hblank = hcnt >= HW'(LINE_PIXELS - LINE_PIXELS / 4);   // Last quarter
        timing.vblank = vcnt >= VW'(FRAME_LINES - VBLANK_LINES);      // Last lines
    end

endmodule

// File: design/objdma_pkg.sv
/* Shared types for the object-attribute DMA: video timing bundle, bank write
   port, renderer object entry and DMA FSM states. Imported by the RTL modules */

package objdma_pkg;

    // Copy length in bytes, fixed by the board
    localparam int DMA_BYTES = 1024;

    // Video timing bundle from the timing generator
    typedef struct packed {
        logic       cen;    // Pixel clock enable
        logic [1:0] phase;  // Pixel phase inside a byte slot
        logic       hblank; // Last quarter of each line
        logic       vblank; // Last lines of each frame
    } video_timing_t;

    // Write port into the four attribute banks
    typedef struct packed {
        logic [3:0] we;     // One-hot bank strobe
        logic [7:0] addr;   // Object index
        logic [7:0] data;   // Byte from work RAM
    } bank_wr_t;

    // One object as seen by the renderer
    typedef struct packed {
        logic [4:0] attr;   // Bank 3, only 5 bits kept
        logic [7:0] b2;     // Bank 2
        logic [7:0] b1;     // Bank 1
        logic [7:0] b0;     // Bank 0
    } obj_entry_t;

    // DMA control states
    typedef enum logic [1:0] {
        DMA_IDLE = 2'd0,    // Waiting for vblank
        DMA_REQ  = 2'd1,    // Bus requested, no grant yet
        DMA_COPY = 2'd2,    // Copying bytes while granted
        DMA_DONE = 2'd3     // Copy over, wait for vblank to end
    } dma_state_t;

endpackage
